// ==== compile.f ====
+incdir+common
common/scope_pkg.sv
hw/raster_timing.sv
capture/span_tracker.sv
capture/column_buffer.sv
hw/trace_renderer.sv
hw/vga_trace_scope.sv
verification/tb_vga_trace_scope.sv

// ==== verification/tb_vga_trace_scope.sv ====
`include "scope_settings.svh"

module tb_vga_trace_scope;

	localparam int FRAME_SAMPLES = 48;
	localparam int VSYNC_STROBES = 6;
	localparam int PIX_LATENCY = 3;
	localparam int FRAME_CYCLES = 2 * (FRAME_SAMPLES + VSYNC_STROBES) + 6;
	localparam int LINE_CYCLES = `SCOPE_COLUMNS + 6;
	localparam int MAX_SKIP = 420;
	localparam int N_FRAMES = 7;
	localparam int N_LINES = 20;
	localparam int PLANNED_CYCLES = N_FRAMES * (FRAME_CYCLES + 2 * MAX_SKIP)
		+ N_LINES * LINE_CYCLES + 16;
	localparam int TIMEOUT_CYCLES = PLANNED_CYCLES * 3 / 2;

	logic clk;
	logic reset;
	logic blank;
	logic vsync;
	logic ad_strobe;
	logic [`SAMPLE_W-1:0] ad_a0;
	logic [`SAMPLE_W-1:0] ad_a1;
	logic [`SAMPLE_W-1:0] ad_b0;
	logic [`SAMPLE_W-1:0] ad_b1;
	logic [7:0] red;
	logic [7:0] green;
	logic [7:0] blue;

	integer seed;
	int error_count;
	int check_count;
	int cycle_count;
	int cur_line;

	// Stimulus ranges in stored levels, per channel
	int rng_lo [`CHAN_COUNT];
	int rng_hi [`CHAN_COUNT];
	logic force_ext;
	scope_pkg::sample_t cur_smp [`CHAN_COUNT];

	// Reference model of the running spans and the written columns
	scope_pkg::sample_t m_lo [`CHAN_COUNT];
	scope_pkg::sample_t m_hi [`CHAN_COUNT];
	scope_pkg::column_t frame_exp;
	scope_pkg::column_t model_cols [$];

	vga_trace_scope uut (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.ad_strobe(ad_strobe),
		.ad_a0(ad_a0),
		.ad_a1(ad_a1),
		.ad_b0(ad_b0),
		.ad_b1(ad_b1),
		.red(red),
		.green(green),
		.blue(blue)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count++;
		if (cycle_count > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, the run did not finish", cycle_count);
			$display("Test failures found");
			$finish;
		end
	end

	////////////////////////////////////////////////////////////
	// Checks and reference model
	////////////////////////////////////////////////////////////

	task automatic check_rgb(input string name, input scope_pkg::rgb_t exp,
			input scope_pkg::rgb_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	task automatic check_column(input string name, input scope_pkg::column_t exp,
			input scope_pkg::column_t act);
		check_count++;
		if (act !== exp) begin
			error_count++;
			$display("Mismatch at %0t: %s expected %h, got %h", $time, name, exp, act);
		end
	endtask

	// Colour of pixel (px, py) from the columns written so far
	function automatic scope_pkg::rgb_t expected_pixel(input int px, input int py);
		scope_pkg::column_t col;
		int back;
		int off;
		logic [`CHAN_COUNT-1:0] lit;
		logic grid;
		back = `SCOPE_COLUMNS - 1 - px;
		if (back < model_cols.size())
			col = model_cols[model_cols.size() - 1 - back];
		else
			col = '0;
		for (int k = 0; k < `CHAN_COUNT; k++) begin
			// Unsigned 10-bit height above the channel base
			off = (py - `SCOPE_TOP_ROW - `CHAN_ROW_STEP * k) & ((1 << `COORD_W) - 1);
			lit[k] = (col[k].lo <= off) && (col[k].hi >= off);
		end
		grid = (px % (1 << `GRID_X_BITS) == (1 << `GRID_X_BITS) - 1)
			|| (py % (1 << `GRID_Y_BITS) == 0);
		if (py < `SCOPE_TOP_ROW) return `COLOR_BLACK;
		if (lit[0]) return `COLOR_A0;
		if (lit[1]) return `COLOR_A1;
		if (lit[2]) return `COLOR_B0;
		if (lit[3]) return `COLOR_B1;
		if (grid) return `COLOR_GRID;
		return `COLOR_BLACK;
	endfunction

	////////////////////////////////////////////////////////////
	// Drivers
	////////////////////////////////////////////////////////////

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge clk);
			#2;
		end
	endtask

	task automatic set_ranges(input int a0_lo, input int a0_hi, input int a1_lo,
			input int a1_hi, input int b0_lo, input int b0_hi, input int b1_lo,
			input int b1_hi);
		rng_lo[0] = a0_lo;
		rng_hi[0] = a0_hi;
		rng_lo[1] = a1_lo;
		rng_hi[1] = a1_hi;
		rng_lo[2] = b0_lo;
		rng_hi[2] = b0_hi;
		rng_lo[3] = b1_lo;
		rng_hi[3] = b1_hi;
	endtask

	// With force_ext the first two samples hit the range ends
	task automatic make_samples(input int idx);
		logic [31:0] rnd;
		int lvl;
		for (int k = 0; k < `CHAN_COUNT; k++) begin
			rnd = $random(seed);
			if (force_ext && idx == 0)
				lvl = rng_lo[k];
			else if (force_ext && idx == 1)
				lvl = rng_hi[k];
			else
				lvl = rng_lo[k] + (rnd[23:8] % (rng_hi[k] - rng_lo[k] + 1));
			cur_smp[k] = {lvl[7:0], rnd[3:0]};
		end
	endtask

	// One strobed cycle followed by one cycle of junk that must be ignored
	task automatic strobe_pair(input logic vs, input logic detect);
		logic [31:0] rnd;
		@(posedge clk);
		#2;
		vsync = vs;
		ad_strobe = 1'b1;
		ad_a0 = cur_smp[0];
		ad_a1 = cur_smp[1];
		ad_b0 = cur_smp[2];
		ad_b1 = cur_smp[3];
		for (int k = 0; k < `CHAN_COUNT; k++) begin
			if (detect) begin
				frame_exp[k].lo = m_lo[k] >> (`SAMPLE_W - `STORE_W);
				frame_exp[k].hi = m_hi[k] >> (`SAMPLE_W - `STORE_W);
				m_lo[k] = cur_smp[k];
				m_hi[k] = cur_smp[k];
			end else begin
				if (cur_smp[k] < m_lo[k]) m_lo[k] = cur_smp[k];
				if (cur_smp[k] > m_hi[k]) m_hi[k] = cur_smp[k];
			end
		end
		@(posedge clk);
		#2;
		ad_strobe = 1'b0;
		rnd = $random(seed);
		ad_a0 = rnd[11:0];
		ad_a1 = rnd[23:12];
		ad_b0 = {rnd[31:24], rnd[3:0]};
		ad_b1 = rnd[19:8];
	endtask

	task automatic run_frame();
		for (int i = 0; i < FRAME_SAMPLES; i++) begin
			make_samples(i);
			strobe_pair(1'b0, 1'b0);
		end
		// The rise shows up on the third strobe after the first high one
		for (int j = 0; j < VSYNC_STROBES; j++) begin
			strobe_pair(1'b1, j == 3);
		end
		idle(1);
		vsync = 1'b0;
		idle(4);
		model_cols.push_back(frame_exp);
		check_column("frame_spans", frame_exp, uut.u_spans.frame_spans);
		cur_line = 0;
	endtask

	// Short blank pulses step the line counter
	task automatic advance_to(input int line_y);
		while (cur_line < line_y) begin
			idle(1);
			blank = 1'b0;
			idle(1);
			blank = 1'b1;
			cur_line++;
		end
	endtask

	task automatic draw_line(input int line_y);
		scope_pkg::rgb_t got;
		idle(1);
		blank = 1'b0;
		for (int n = 1; n <= `SCOPE_COLUMNS + PIX_LATENCY - 1; n++) begin
			idle(1);
			if (n >= PIX_LATENCY) begin
				got = {red, green, blue};
				check_rgb($sformatf("rgb x=%0d y=%0d", n - PIX_LATENCY, line_y),
					expected_pixel(n - PIX_LATENCY, line_y), got);
			end
			if (n == `SCOPE_COLUMNS) blank = 1'b1;
		end
		cur_line = line_y + 1;
	endtask

	task automatic show_line(input int line_y);
		advance_to(line_y);
		draw_line(line_y);
	endtask

	////////////////////////////////////////////////////////////
	// Tests
	////////////////////////////////////////////////////////////

	// Any line above the scope area renders black, whatever y is
	task automatic test_reset_black();
		idle(1);
		for (int i = 0; i < 4; i++) begin
			idle(1);
			check_rgb("rgb after reset", `COLOR_BLACK, {red, green, blue});
		end
		draw_line(0);
		draw_line(1);
	endtask

	task automatic test_capture();
		int lo;
		int hi;
		force_ext = 1'b0;
		set_ranges(40, 90, 4, 4, 20, 20, 10, 10);
		run_frame();
		run_frame();
		lo = frame_exp[0].lo;
		hi = frame_exp[0].hi;
		show_line(200);
		show_line(`SCOPE_TOP_ROW + lo - 1);
		show_line(`SCOPE_TOP_ROW + lo);
		show_line(`SCOPE_TOP_ROW + hi);
		show_line(`SCOPE_TOP_ROW + hi + 1);
	endtask

	// Older column at x=798 has A0 starting higher, so A1 alone shows red
	task automatic test_priority();
		force_ext = 1'b1;
		set_ranges(36, 40, 0, 8, 10, 20, 3, 6);
		run_frame();
		set_ranges(32, 40, 0, 8, 10, 20, 3, 6);
		run_frame();
		show_line(256);
		show_line(258);
		show_line(260);
		show_line(264);
		show_line(265);
		show_line(300);
		show_line(324);
	endtask

	task automatic test_scroll();
		force_ext = 1'b1;
		set_ranges(100, 110, 50, 50, 20, 20, 10, 10);
		run_frame();
		set_ranges(150, 160, 50, 50, 20, 20, 10, 10);
		run_frame();
		show_line(306);
		show_line(330);
		show_line(344);
		show_line(384);
	endtask

	task automatic test_grid();
		force_ext = 1'b0;
		set_ranges(2, 2, 2, 2, 2, 2, 2, 2);
		run_frame();
		show_line(230);
		show_line(416);
	endtask

	initial begin
		seed = 32'h61f3;
		error_count = 0;
		check_count = 0;
		cycle_count = 0;
		cur_line = 0;
		force_ext = 1'b0;
		frame_exp = '0;
		for (int k = 0; k < `CHAN_COUNT; k++) begin
			m_lo[k] = '0;
			m_hi[k] = '0;
			cur_smp[k] = '0;
		end
		reset = 1'b1;
		blank = 1'b1;
		vsync = 1'b0;
		ad_strobe = 1'b0;
		ad_a0 = '0;
		ad_a1 = '0;
		ad_b0 = '0;
		ad_b1 = '0;
		repeat (2) @(posedge clk);
		#2;
		reset = 1'b0;

		test_reset_black();
		test_capture();
		test_priority();
		test_scroll();
		test_grid();

		$display("Checks: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

// ==== hw/vga_trace_scope.sv ====
`include "scope_settings.svh"

module vga_trace_scope (
	input logic clk,
	input logic reset,
	input logic blank,
	input logic vsync,
	input logic ad_strobe,
	input logic [`SAMPLE_W-1:0] ad_a0,
	input logic [`SAMPLE_W-1:0] ad_a1,
	input logic [`SAMPLE_W-1:0] ad_b0,
	input logic [`SAMPLE_W-1:0] ad_b1,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	scope_pkg::coord_t x;
	scope_pkg::coord_t y;
	scope_pkg::column_t frame_spans;
	scope_pkg::column_t col_data;

	raster_timing u_raster (
		.clk(clk),
		.reset(reset),
		.blank(blank),
		.vsync(vsync),
		.x(x),
		.y(y)
	);

	// Capture runs on the strobed sample stream
	span_tracker u_spans (
		.clk(clk),
		.reset(reset),
		.vsync(vsync),
		.ad_strobe(ad_strobe),
		.ad_a0(ad_a0),
		.ad_a1(ad_a1),
		.ad_b0(ad_b0),
		.ad_b1(ad_b1),
		.frame_spans(frame_spans)
	);

	column_buffer u_buffer (
		.clk(clk),
		.reset(reset),
		.vsync(vsync),
		.x(x),
		.frame_spans(frame_spans),
		.col_data(col_data)
	);

	// Colour for pixel x shows three clocks after x
	trace_renderer u_render (
		.clk(clk),
		.reset(reset),
		.x(x),
		.y(y),
		.col_data(col_data),
		.red(red),
		.green(green),
		.blue(blue)
	);

endmodule

// ==== hw/trace_renderer.sv ====
`include "scope_settings.svh"

module trace_renderer (
	input logic clk,
	input logic reset,
	input scope_pkg::coord_t x,
	input scope_pkg::coord_t y,
	input scope_pkg::column_t col_data,
	output logic [7:0] red,
	output logic [7:0] green,
	output logic [7:0] blue
);

	scope_pkg::coord_t x_d1, x_d2;
	scope_pkg::coord_t y_d1, y_d2;
	scope_pkg::coord_t row_off [`CHAN_COUNT];
	logic [`CHAN_COUNT-1:0] chan_hit;
	logic [`CHAN_COUNT-1:0] chan_on;
	logic grid_on;
	scope_pkg::rgb_t pix;

	// Line up the counters with the column read
	always_ff @(posedge clk) begin
		x_d1 <= x;
		x_d2 <= x_d1;
		y_d1 <= y;
		y_d2 <= y_d1;
	end

	// Height of this row above each channel's base.
	// Rows above the base wrap to large values and miss
	always_comb begin
		for (int k = 0; k < `CHAN_COUNT; k++) begin
			row_off[k] = y_d2 - scope_pkg::coord_t'(`SCOPE_TOP_ROW + `CHAN_ROW_STEP * k);
			chan_hit[k] = (scope_pkg::coord_t'(col_data[k].lo) <= row_off[k])
				&& (scope_pkg::coord_t'(col_data[k].hi) >= row_off[k]);
		end
	end

	////////////////////////////////////////////////////////////
	// Pixel flags
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			chan_on <= '0;
			grid_on <= 1'b0;
		end else if (y_d2 < scope_pkg::coord_t'(`SCOPE_TOP_ROW)) begin
			chan_on <= '0;
			grid_on <= 1'b0;
		end else begin
			chan_on <= chan_hit;
			grid_on <= (x_d2[`GRID_X_BITS-1:0] == '1) || (y_d2[`GRID_Y_BITS-1:0] == '0);
		end
	end

	// Colour priority, A0 on top and the grid behind all traces
	always_comb begin
		if (chan_on[0]) pix = `COLOR_A0;
		else if (chan_on[1]) pix = `COLOR_A1;
		else if (chan_on[2]) pix = `COLOR_B0;
		else if (chan_on[3]) pix = `COLOR_B1;
		else if (grid_on) pix = `COLOR_GRID;
		else pix = `COLOR_BLACK;
	end

	assign red = pix.red;
	assign green = pix.green;
	assign blue = pix.blue;

	// Nothing lights above the scope area
	a_black_above_scope: assert property (
		@(posedge clk) disable iff (reset)
		(y_d2 < scope_pkg::coord_t'(`SCOPE_TOP_ROW)) |=> (chan_on == '0 && !grid_on)
	);

endmodule

// ==== capture/column_buffer.sv ====
`include "scope_settings.svh"

module column_buffer (
	input logic clk,
	input logic reset,
	input logic vsync,
	input scope_pkg::coord_t x,
	input scope_pkg::column_t frame_spans,
	output scope_pkg::column_t col_data
);

	localparam int DEPTH = 1 << `BUF_ADDR_W;

	scope_pkg::column_t mem [DEPTH];
	scope_pkg::buf_addr_t wr_addr;
	scope_pkg::buf_addr_t rd_addr;
	logic vsync_d1;
	logic vsync_fall;
	logic we;

	// Empty spans in every column until it is first written
	initial begin
		for (int i = 0; i < DEPTH; i++) begin
			mem[i] = '0;
		end
	end

	////////////////////////////////////////////////////////////
	// Write side, one column per frame
	////////////////////////////////////////////////////////////

	assign vsync_fall = !vsync && vsync_d1;

	// Pointer moves first, the column lands there a cycle later.
	// Starting at the top means the first column goes to 0
	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_d1 <= 1'b0;
			we <= 1'b0;
			wr_addr <= '1;
		end else begin
			vsync_d1 <= vsync;
			we <= vsync_fall;
			if (vsync_fall) begin
				wr_addr <= wr_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (we) begin
			mem[wr_addr] <= frame_spans;
		end
	end

	////////////////////////////////////////////////////////////
	// Read side, scrolling with the pixel counter
	////////////////////////////////////////////////////////////

	// Pixel 0 is the oldest shown column, pixel 799 the newest
	always_ff @(posedge clk) begin
		rd_addr <= wr_addr - scope_pkg::buf_addr_t'(`SCOPE_COLUMNS - 1)
			+ scope_pkg::buf_addr_t'(x);
	end

	// Registered memory output, col_data trails x by two clocks
	always_ff @(posedge clk) begin
		col_data <= mem[rd_addr];
	end

	// Only one column is written per vsync fall
	a_single_write: assert property (
		@(posedge clk) disable iff (reset)
		we |=> !we
	);

endmodule

// ==== capture/span_tracker.sv ====
`include "scope_settings.svh"

module span_tracker (
	input logic clk,
	input logic reset,
	input logic vsync,
	input logic ad_strobe,
	input scope_pkg::sample_t ad_a0,
	input scope_pkg::sample_t ad_a1,
	input scope_pkg::sample_t ad_b0,
	input scope_pkg::sample_t ad_b1,
	output scope_pkg::column_t frame_spans
);

	scope_pkg::sample_t samp [`CHAN_COUNT];
	scope_pkg::sample_t cur_lo [`CHAN_COUNT];
	scope_pkg::sample_t cur_hi [`CHAN_COUNT];
	logic [3:0] vsync_del;
	logic vsync_rise;

	assign samp[0] = ad_a0;
	assign samp[1] = ad_a1;
	assign samp[2] = ad_b0;
	assign samp[3] = ad_b1;

	////////////////////////////////////////////////////////////
	// Frame boundary on the sample grid
	////////////////////////////////////////////////////////////

	// vsync only advances through the delay on strobe cycles,
	// so the rise lands on a strobe with a valid sample
	assign vsync_rise = ad_strobe && vsync_del[2] && !vsync_del[3];

	always_ff @(posedge clk) begin
		if (reset) begin
			vsync_del <= '0;
		end else if (ad_strobe) begin
			vsync_del <= {vsync_del[2:0], vsync};
		end
	end

	////////////////////////////////////////////////////////////
	// Running min and max per channel
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < `CHAN_COUNT; k++) begin
				cur_lo[k] <= '0;
				cur_hi[k] <= '0;
			end
		end else if (ad_strobe) begin
			for (int k = 0; k < `CHAN_COUNT; k++) begin
				if (vsync_rise) begin
					// New frame starts from this sample
					cur_lo[k] <= samp[k];
					cur_hi[k] <= samp[k];
				end else begin
					// Full width compare, truncation happens on hand-over
					if (samp[k] < cur_lo[k]) begin
						cur_lo[k] <= samp[k];
					end
					if (samp[k] > cur_hi[k]) begin
						cur_hi[k] <= samp[k];
					end
				end
			end
		end
	end

	// Frame result, held until the next vsync rise
	always_ff @(posedge clk) begin
		if (reset) begin
			frame_spans <= '0;
		end else if (vsync_rise) begin
			for (int k = 0; k < `CHAN_COUNT; k++) begin
				frame_spans[k].lo <= cur_lo[k][`SAMPLE_W-1 -: `STORE_W];
				frame_spans[k].hi <= cur_hi[k][`SAMPLE_W-1 -: `STORE_W];
			end
		end
	end

	// A span never inverts, whether it widened or restarted
	for (genvar g = 0; g < `CHAN_COUNT; g++) begin : g_span_check
		a_span_ordered: assert property (
			@(posedge clk) disable iff (reset)
			ad_strobe |=> (cur_lo[g] <= cur_hi[g])
		);
	end

endmodule

// ==== hw/raster_timing.sv ====
`include "scope_settings.svh"

module raster_timing (
	input logic clk,
	input logic reset,
	input logic blank,
	input logic vsync,
	output scope_pkg::coord_t x,
	output scope_pkg::coord_t y
);

	logic blank_d1;

	// Pixel counter holds at zero through blanking
	// Line counter steps on the start of each blanking interval
	always_ff @(posedge clk) begin
		if (reset) begin
			blank_d1 <= 1'b0;
			x <= '0;
			y <= '0;
		end else begin
			blank_d1 <= blank;
			if (blank) begin
				x <= '0;
			end else begin
				x <= x + 1'b1;
			end
			if (vsync) begin
				y <= '0;
			end else if (blank && !blank_d1) begin
				y <= y + 1'b1;
			end
		end
	end

	// Each visible line starts counting from pixel zero
	a_x_cleared_by_blank: assert property (
		@(posedge clk) disable iff (reset)
		blank |=> (x == '0)
	);

endmodule

// ==== common/scope_pkg.sv ====
`include "scope_settings.svh"

package scope_pkg;

	// One raw converter sample
	typedef logic [`SAMPLE_W-1:0] sample_t;

	// Level kept in the column buffer, top bits of a sample
	typedef logic [`STORE_W-1:0] level_t;

	// Vertical extent of one channel over one frame
	typedef struct packed {
		level_t hi;
		level_t lo;
	} span_t;

	////////////////////////////////////////////////////////////
	// One scope column
	////////////////////////////////////////////////////////////

	// Index 0 is A0, then A1, B0, B1
	typedef span_t [`CHAN_COUNT-1:0] column_t;

	// Pixel within a line or line within a frame
	typedef logic [`COORD_W-1:0] coord_t;

	// Address into the circular column buffer
	typedef logic [`BUF_ADDR_W-1:0] buf_addr_t;

	////////////////////////////////////////////////////////////
	// Video output
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [7:0] red;
		logic [7:0] green;
		logic [7:0] blue;
	} rgb_t;

endpackage

// ==== common/scope_settings.svh ====
`ifndef SCOPE_SETTINGS_SVH
`define SCOPE_SETTINGS_SVH

// Converter sample and stored level widths
`define SAMPLE_W 12
`define STORE_W 8

// Four converter channels A0, A1, B0, B1
`define CHAN_COUNT 4

// Column buffer, 1024 columns deep
`define BUF_ADDR_W 10
`define SCOPE_COLUMNS 800

// Pixel and line counters
`define COORD_W 10

////////////////////////////////////////////////////////////
// Screen geometry of the scope area
////////////////////////////////////////////////////////////
`define SCOPE_TOP_ROW 224
`define CHAN_ROW_STEP 32
`define GRID_X_BITS 6
`define GRID_Y_BITS 5

// Colour words as {red, green, blue}
`define COLOR_A0 24'hffffff
`define COLOR_A1 24'hff0000
`define COLOR_B0 24'h00ff00
`define COLOR_B1 24'h0000ff
`define COLOR_GRID 24'h808080
`define COLOR_BLACK 24'h000000

`endif
